// ==== hw/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // ------------------------------------------------------------------------
    // major opcodes of the kept subset
    // ------------------------------------------------------------------------
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_I      = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    // ALU and branch funct3 share one encoding space
    typedef enum logic [2:0] {
        F3_ADD_BEQ = 3'b000,  // add, sub, addi, beq
        F3_BNE     = 3'b001,
        F3_SLT     = 3'b010,  // also lw / sw width
        F3_XOR     = 3'b100,
        F3_OR      = 3'b110,
        F3_AND     = 3'b111
    } funct3_e;

    localparam word_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0

endpackage

`default_nettype wire

// ==== hw/rv_pipe_pkg.sv ====
`default_nettype none

package rv_pipe_pkg;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } result_src_e;

    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwd_sel_e;

    // all-zero ctrl is a bubble
    typedef struct packed {
        logic                reg_write;
        logic                mem_write;
        logic                branch;
        logic                jump;
        logic                is_load;
        logic                alu_src_imm;
        alu_op_e             alu_op;
        result_src_e         result_src;
        rv_isa_pkg::funct3_e funct3;
    } ctrl_t;

    // ------------------------------------------------------------------------
    // stage registers
    // ------------------------------------------------------------------------
    typedef struct packed {
        rv_isa_pkg::word_t instr;
        rv_isa_pkg::word_t pc;
    } if_id_t;

    typedef struct packed {
        ctrl_t                ctrl;
        rv_isa_pkg::word_t    pc;
        rv_isa_pkg::word_t    rs1_val;
        rv_isa_pkg::word_t    rs2_val;
        rv_isa_pkg::word_t    imm;
        rv_isa_pkg::reg_idx_t rs1;
        rv_isa_pkg::reg_idx_t rs2;
        rv_isa_pkg::reg_idx_t rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                ctrl;
        rv_isa_pkg::word_t    alu_out;
        rv_isa_pkg::word_t    store_data;
        rv_isa_pkg::word_t    pc_plus4;
        rv_isa_pkg::reg_idx_t rd;
    } ex_mem_t;

    typedef struct packed {
        logic                 reg_write;
        result_src_e          result_src;
        rv_isa_pkg::word_t    alu_out;
        rv_isa_pkg::word_t    load_data;
        rv_isa_pkg::word_t    pc_plus4;
        rv_isa_pkg::reg_idx_t rd;
    } mem_wb_t;

endpackage

`default_nettype wire

// ==== hw/rv_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_decoder (
    input  rv_isa_pkg::word_t    i_instr,
    output rv_pipe_pkg::ctrl_t   o_ctrl,
    output rv_isa_pkg::word_t    o_imm,
    output rv_isa_pkg::reg_idx_t o_rs1,
    output rv_isa_pkg::reg_idx_t o_rs2,
    output rv_isa_pkg::reg_idx_t o_rd
);

    rv_isa_pkg::opcode_e opcode;
    rv_isa_pkg::funct3_e funct3;
    logic                funct7_b5;

    assign opcode    = rv_isa_pkg::opcode_e'(i_instr[6:0]);
    assign funct3    = rv_isa_pkg::funct3_e'(i_instr[14:12]);
    assign funct7_b5 = i_instr[30];

    assign o_rs1 = i_instr[19:15];
    assign o_rs2 = i_instr[24:20];
    assign o_rd  = i_instr[11:7];

    always_comb
    begin
        o_ctrl        = '0;
        o_ctrl.funct3 = funct3;
        o_imm         = '0;
        case (opcode)
            rv_isa_pkg::OP_R:
            begin
                o_ctrl.reg_write = 1'b1;
                case (funct3)
                    rv_isa_pkg::F3_ADD_BEQ:
                        o_ctrl.alu_op = funct7_b5 ? rv_pipe_pkg::ALU_SUB : rv_pipe_pkg::ALU_ADD;
                    rv_isa_pkg::F3_SLT: o_ctrl.alu_op = rv_pipe_pkg::ALU_SLT;
                    rv_isa_pkg::F3_XOR: o_ctrl.alu_op = rv_pipe_pkg::ALU_XOR;
                    rv_isa_pkg::F3_OR:  o_ctrl.alu_op = rv_pipe_pkg::ALU_OR;
                    rv_isa_pkg::F3_AND: o_ctrl.alu_op = rv_pipe_pkg::ALU_AND;
                    default:            o_ctrl.alu_op = rv_pipe_pkg::ALU_ADD;
                endcase
            end
            rv_isa_pkg::OP_I:
            begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;  // addi only
                o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            rv_isa_pkg::OP_LOAD:
            begin
                o_ctrl.reg_write   = 1'b1;
                o_ctrl.is_load     = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_ctrl.result_src  = rv_pipe_pkg::RES_MEM;
                o_imm = {{20{i_instr[31]}}, i_instr[31:20]};
            end
            rv_isa_pkg::OP_STORE:
            begin
                o_ctrl.mem_write   = 1'b1;
                o_ctrl.alu_src_imm = 1'b1;
                o_imm = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
            end
            rv_isa_pkg::OP_BRANCH:
            begin
                o_ctrl.branch = 1'b1;
                o_imm = {{19{i_instr[31]}}, i_instr[31], i_instr[7],
                         i_instr[30:25], i_instr[11:8], 1'b0};
            end
            rv_isa_pkg::OP_JAL:
            begin
                o_ctrl.jump       = 1'b1;
                o_ctrl.reg_write  = 1'b1;
                o_ctrl.result_src = rv_pipe_pkg::RES_PC4;
                o_imm = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12],
                         i_instr[20], i_instr[30:21], 1'b0};
            end
            default: ;  // unknown opcode behaves as a bubble
        endcase
        // x0 writes never leave decode
        if (o_rd == '0)
            o_ctrl.reg_write = 1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/rv_regfile.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_regfile (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  logic                 i_we,
    input  rv_isa_pkg::reg_idx_t i_waddr,
    input  rv_isa_pkg::word_t    i_wdata,
    input  rv_isa_pkg::reg_idx_t i_raddr1,
    input  rv_isa_pkg::reg_idx_t i_raddr2,
    output rv_isa_pkg::word_t    o_rdata1,
    output rv_isa_pkg::word_t    o_rdata2
);

    rv_isa_pkg::word_t regs [1:31];  // x0 is not stored

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end
        else if (i_we && i_waddr != '0)
            regs[i_waddr] <= i_wdata;
    end

    // writeback to decode bypass
    assign o_rdata1 = (i_raddr1 == '0)                ? '0 :
                      (i_we && i_waddr == i_raddr1)   ? i_wdata : regs[i_raddr1];
    assign o_rdata2 = (i_raddr2 == '0)                ? '0 :
                      (i_we && i_waddr == i_raddr2)   ? i_wdata : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== hw/rv_hazard_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_hazard_unit (
    input  rv_isa_pkg::reg_idx_t  i_rs1_d,
    input  rv_isa_pkg::reg_idx_t  i_rs2_d,
    input  rv_isa_pkg::reg_idx_t  i_rs1_e,
    input  rv_isa_pkg::reg_idx_t  i_rs2_e,
    input  rv_isa_pkg::reg_idx_t  i_rd_e,
    input  logic                  i_load_e,
    input  rv_isa_pkg::reg_idx_t  i_rd_m,
    input  logic                  i_wr_m,
    input  rv_isa_pkg::reg_idx_t  i_rd_w,
    input  logic                  i_wr_w,
    input  logic                  i_redirect_e,
    output rv_pipe_pkg::fwd_sel_e o_fwd_a,
    output rv_pipe_pkg::fwd_sel_e o_fwd_b,
    output logic                  o_stall,
    output logic                  o_flush
);

    // reg_write is never set for rd == x0, so no zero check here
    function automatic rv_pipe_pkg::fwd_sel_e fwd_for(
        input rv_isa_pkg::reg_idx_t rs,
        input rv_isa_pkg::reg_idx_t rd_m,
        input logic                 wr_m,
        input rv_isa_pkg::reg_idx_t rd_w,
        input logic                 wr_w
    );
        if (wr_m && rd_m == rs)
            return rv_pipe_pkg::FWD_MEM;  // youngest value wins
        else if (wr_w && rd_w == rs)
            return rv_pipe_pkg::FWD_WB;
        else
            return rv_pipe_pkg::FWD_REG;
    endfunction

    assign o_fwd_a = fwd_for(i_rs1_e, i_rd_m, i_wr_m, i_rd_w, i_wr_w);
    assign o_fwd_b = fwd_for(i_rs2_e, i_rd_m, i_wr_m, i_rd_w, i_wr_w);

    // load data only exists after memory, so hold decode one cycle
    assign o_stall = i_load_e && i_rd_e != '0 && (i_rd_e == i_rs1_d || i_rd_e == i_rs2_d);
    assign o_flush = i_redirect_e;

endmodule

`default_nettype wire

// ==== hw/rv_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_execute (
    input  rv_pipe_pkg::id_ex_t   i_id_ex,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_a,
    input  rv_pipe_pkg::fwd_sel_e i_fwd_b,
    input  rv_isa_pkg::word_t     i_mem_fwd,
    input  rv_isa_pkg::word_t     i_wb_fwd,
    output rv_isa_pkg::word_t     o_alu_out,
    output rv_isa_pkg::word_t     o_store_data,
    output rv_isa_pkg::word_t     o_target,
    output logic                  o_redirect
);

    rv_isa_pkg::word_t src_a;
    rv_isa_pkg::word_t src_b;
    rv_isa_pkg::word_t op_b;
    logic              equal;
    logic              taken;

    function automatic rv_isa_pkg::word_t fwd_mux(
        input rv_pipe_pkg::fwd_sel_e sel,
        input rv_isa_pkg::word_t     reg_val,
        input rv_isa_pkg::word_t     mem_val,
        input rv_isa_pkg::word_t     wb_val
    );
        case (sel)
            rv_pipe_pkg::FWD_MEM: return mem_val;
            rv_pipe_pkg::FWD_WB:  return wb_val;
            default:              return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(i_fwd_a, i_id_ex.rs1_val, i_mem_fwd, i_wb_fwd);
    assign src_b = fwd_mux(i_fwd_b, i_id_ex.rs2_val, i_mem_fwd, i_wb_fwd);
    assign op_b  = i_id_ex.ctrl.alu_src_imm ? i_id_ex.imm : src_b;

    always_comb
    begin
        case (i_id_ex.ctrl.alu_op)
            rv_pipe_pkg::ALU_SUB: o_alu_out = src_a - op_b;
            rv_pipe_pkg::ALU_AND: o_alu_out = src_a & op_b;
            rv_pipe_pkg::ALU_OR:  o_alu_out = src_a | op_b;
            rv_pipe_pkg::ALU_XOR: o_alu_out = src_a ^ op_b;
            rv_pipe_pkg::ALU_SLT: o_alu_out = {31'b0, $signed(src_a) < $signed(op_b)};
            default:              o_alu_out = src_a + op_b;
        endcase
    end

    assign o_store_data = src_b;

    // branch compare runs on the forwarded register values
    assign equal      = (src_a == src_b);
    assign taken      = i_id_ex.ctrl.branch &&
                        ((i_id_ex.ctrl.funct3 == rv_isa_pkg::F3_BNE) ? !equal : equal);
    assign o_redirect = taken || i_id_ex.ctrl.jump;
    assign o_target   = i_id_ex.pc + i_id_ex.imm;  // beq, bne, jal

endmodule

`default_nettype wire

// ==== hw/rv_data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_data_mem #(
    parameter int DMEM_WORDS = 256
) (
    input  logic              i_clk,
    input  logic              i_we,
    input  rv_isa_pkg::word_t i_addr,
    input  rv_isa_pkg::word_t i_wdata,
    output rv_isa_pkg::word_t o_rdata
);

    localparam int ADDR_W = $clog2(DMEM_WORDS);

    rv_isa_pkg::word_t       mem [DMEM_WORDS];
    logic [ADDR_W-1:0]       word_idx;

    assign word_idx = i_addr[ADDR_W+1:2];  // byte offset dropped

    always_ff @(posedge i_clk)
    begin
        if (i_we)
            mem[word_idx] <= i_wdata;
    end

    assign o_rdata = mem[word_idx];

endmodule

`default_nettype wire

// ==== hw/rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core #(
    parameter rv_isa_pkg::word_t RESET_PC   = '0,
    parameter int                DMEM_WORDS = 256
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  rv_isa_pkg::word_t    i_imem_data,
    output rv_isa_pkg::word_t    o_imem_addr,
    output logic                 o_wb_valid,
    output rv_isa_pkg::reg_idx_t o_wb_rd,
    output rv_isa_pkg::word_t    o_wb_data
);

    rv_isa_pkg::word_t     pc_f;
    rv_pipe_pkg::if_id_t   if_id_q;
    rv_pipe_pkg::id_ex_t   id_ex_q;
    rv_pipe_pkg::ex_mem_t  ex_mem_q;
    rv_pipe_pkg::mem_wb_t  mem_wb_q;

    rv_pipe_pkg::ctrl_t    ctrl_d;
    rv_isa_pkg::word_t     imm_d;
    rv_isa_pkg::reg_idx_t  rs1_d;
    rv_isa_pkg::reg_idx_t  rs2_d;
    rv_isa_pkg::reg_idx_t  rd_d;
    rv_isa_pkg::word_t     rdata1_d;
    rv_isa_pkg::word_t     rdata2_d;

    rv_pipe_pkg::fwd_sel_e fwd_a;
    rv_pipe_pkg::fwd_sel_e fwd_b;
    logic                  stall;
    logic                  flush;

    rv_isa_pkg::word_t     alu_out_e;
    rv_isa_pkg::word_t     store_data_e;
    rv_isa_pkg::word_t     target_e;
    logic                  redirect_e;

    rv_isa_pkg::word_t     load_data_m;
    rv_isa_pkg::word_t     mem_fwd_m;
    rv_isa_pkg::word_t     result_w;

    // ------------------------------------------------------------------------
    // fetch
    // ------------------------------------------------------------------------
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            pc_f <= RESET_PC;
        else if (redirect_e)
            pc_f <= target_e;
        else if (!stall)
            pc_f <= pc_f + 32'd4;
    end

    assign o_imem_addr = pc_f;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            if_id_q <= '{instr: rv_isa_pkg::NOP_INSTR, pc: RESET_PC};
        else if (flush)
            if_id_q <= '{instr: rv_isa_pkg::NOP_INSTR, pc: pc_f};
        else if (!stall)
            if_id_q <= '{instr: i_imem_data, pc: pc_f};
    end

    // ------------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------------
    rv_decoder u_decoder (
        .i_instr (if_id_q.instr),
        .o_ctrl  (ctrl_d),
        .o_imm   (imm_d),
        .o_rs1   (rs1_d),
        .o_rs2   (rs2_d),
        .o_rd    (rd_d)
    );

    rv_regfile u_regfile (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_we     (mem_wb_q.reg_write),
        .i_waddr  (mem_wb_q.rd),
        .i_wdata  (result_w),
        .i_raddr1 (rs1_d),
        .i_raddr2 (rs2_d),
        .o_rdata1 (rdata1_d),
        .o_rdata2 (rdata2_d)
    );

    rv_hazard_unit u_hazard_unit (
        .i_rs1_d      (rs1_d),
        .i_rs2_d      (rs2_d),
        .i_rs1_e      (id_ex_q.rs1),
        .i_rs2_e      (id_ex_q.rs2),
        .i_rd_e       (id_ex_q.rd),
        .i_load_e     (id_ex_q.ctrl.is_load),
        .i_rd_m       (ex_mem_q.rd),
        .i_wr_m       (ex_mem_q.ctrl.reg_write),
        .i_rd_w       (mem_wb_q.rd),
        .i_wr_w       (mem_wb_q.reg_write),
        .i_redirect_e (redirect_e),
        .o_fwd_a      (fwd_a),
        .o_fwd_b      (fwd_b),
        .o_stall      (stall),
        .o_flush      (flush)
    );

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            id_ex_q <= '0;
        else if (flush || stall)
            id_ex_q <= '0;  // bubble
        else
            id_ex_q <= '{ctrl: ctrl_d, pc: if_id_q.pc, rs1_val: rdata1_d,
                         rs2_val: rdata2_d, imm: imm_d, rs1: rs1_d, rs2: rs2_d, rd: rd_d};
    end

    // ------------------------------------------------------------------------
    // execute
    // ------------------------------------------------------------------------
    rv_execute u_execute (
        .i_id_ex      (id_ex_q),
        .i_fwd_a      (fwd_a),
        .i_fwd_b      (fwd_b),
        .i_mem_fwd    (mem_fwd_m),
        .i_wb_fwd     (result_w),
        .o_alu_out    (alu_out_e),
        .o_store_data (store_data_e),
        .o_target     (target_e),
        .o_redirect   (redirect_e)
    );

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            ex_mem_q <= '0;
        else
            ex_mem_q <= '{ctrl: id_ex_q.ctrl, alu_out: alu_out_e, store_data: store_data_e,
                          pc_plus4: id_ex_q.pc + 32'd4, rd: id_ex_q.rd};
    end

    // ------------------------------------------------------------------------
    // memory
    // ------------------------------------------------------------------------
    rv_data_mem #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_data_mem (
        .i_clk   (i_clk),
        .i_we    (ex_mem_q.ctrl.mem_write),
        .i_addr  (ex_mem_q.alu_out),
        .i_wdata (ex_mem_q.store_data),
        .o_rdata (load_data_m)
    );

    // jal link value must forward too
    assign mem_fwd_m = (ex_mem_q.ctrl.result_src == rv_pipe_pkg::RES_PC4) ?
                       ex_mem_q.pc_plus4 : ex_mem_q.alu_out;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            mem_wb_q <= '0;
        else
            mem_wb_q <= '{reg_write: ex_mem_q.ctrl.reg_write,
                          result_src: ex_mem_q.ctrl.result_src,
                          alu_out: ex_mem_q.alu_out, load_data: load_data_m,
                          pc_plus4: ex_mem_q.pc_plus4, rd: ex_mem_q.rd};
    end

    // ------------------------------------------------------------------------
    // writeback
    // ------------------------------------------------------------------------
    always_comb
    begin
        case (mem_wb_q.result_src)
            rv_pipe_pkg::RES_MEM: result_w = mem_wb_q.load_data;
            rv_pipe_pkg::RES_PC4: result_w = mem_wb_q.pc_plus4;
            default:              result_w = mem_wb_q.alu_out;
        endcase
    end

    assign o_wb_valid = mem_wb_q.reg_write;  // already low for x0
    assign o_wb_rd    = mem_wb_q.rd;
    assign o_wb_data  = result_w;

endmodule

`default_nettype wire

// ==== tests/rv_core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_checker #(
    parameter int                EXP_MAX  = 64,
    parameter rv_isa_pkg::word_t FIRST_PC = '0
) (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  rv_isa_pkg::word_t    i_imem_addr,
    input  logic                 i_wb_valid,
    input  rv_isa_pkg::reg_idx_t i_wb_rd,
    input  rv_isa_pkg::word_t    i_wb_data,
    input  int                   i_exp_count,
    input  rv_isa_pkg::reg_idx_t i_exp_rd [EXP_MAX],
    input  rv_isa_pkg::word_t    i_exp_data [EXP_MAX],
    output int                   o_seen,
    output int                   o_errors
);

    int   seen = 0;
    int   errors = 0;
    logic first_pending = 1'b1;

    assign o_seen   = seen;
    assign o_errors = errors;

    // mid-cycle sampling, outputs settled by then
    always @(negedge i_clk)
    begin
        if (i_rst)
        begin
            if (i_wb_valid !== 1'b0)
            begin
                $display("o_wb_valid is not low while reset is held");
                errors++;
            end
        end
        else
        begin
            if (first_pending)
            begin
                if (i_imem_addr !== FIRST_PC)
                begin
                    $display("MISMATCH o_imem_addr first fetch: expected %h, got %h",
                             FIRST_PC, i_imem_addr);
                    errors++;
                end
                first_pending = 1'b0;
            end
            if (i_wb_valid)
            begin
                if (seen >= i_exp_count)
                begin
                    $display("extra writeback to x%0d with data %h beyond the %0d expected",
                             i_wb_rd, i_wb_data, i_exp_count);
                    errors++;
                end
                else
                begin
                    if (i_wb_rd !== i_exp_rd[seen])
                    begin
                        $display("MISMATCH o_wb_rd #%0d: expected %h, got %h",
                                 seen, i_exp_rd[seen], i_wb_rd);
                        errors++;
                    end
                    if (i_wb_data !== i_exp_data[seen])
                    begin
                        $display("MISMATCH o_wb_data #%0d: expected %h, got %h",
                                 seen, i_exp_data[seen], i_wb_data);
                        errors++;
                    end
                end
                seen++;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tests/rv_core_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core_assert (
    input  logic                 i_clk,
    input  logic                 i_rst,
    input  rv_isa_pkg::word_t    i_imem_addr,
    input  logic                 i_wb_valid,
    input  rv_isa_pkg::reg_idx_t i_wb_rd
);

    int failures = 0;

    wb_rd_nonzero: assert property (@(posedge i_clk) disable iff (i_rst)
        i_wb_valid |-> i_wb_rd != '0)
    else
    begin
        failures++;
        $error("writeback strobe raised for x0");
    end

    fetch_known: assert property (@(posedge i_clk) disable iff (i_rst)
        !$isunknown(i_imem_addr))
    else
    begin
        failures++;
        $error("fetch address has unknown bits");
    end

    fetch_aligned: assert property (@(posedge i_clk) disable iff (i_rst)
        i_imem_addr[1:0] == 2'b00)
    else
    begin
        failures++;
        $error("fetch address is not word aligned");
    end

endmodule

bind rv_core rv_core_assert u_rv_core_assert (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_imem_addr (o_imem_addr),
    .i_wb_valid  (o_wb_valid),
    .i_wb_rd     (o_wb_rd)
);

`default_nettype wire

// ==== tests/tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    localparam int                CLK_PERIOD   = 100;
    localparam int                IMEM_WORDS   = 64;
    localparam int                IMEM_AW      = $clog2(IMEM_WORDS);
    localparam int                EXP_MAX      = 64;
    localparam int                TRACE_WORDS  = 256;
    localparam int                DRAIN_CYCLES = 8;   // deeper than the pipeline
    localparam int                DMEM_WORDS   = 256;
    localparam rv_isa_pkg::word_t RESET_PC     = '0;

    logic                 clk;
    logic                 rst;
    rv_isa_pkg::word_t    imem_addr;
    rv_isa_pkg::word_t    imem_data;
    rv_isa_pkg::word_t    fetch_idx;
    logic                 wb_valid;
    rv_isa_pkg::reg_idx_t wb_rd;
    rv_isa_pkg::word_t    wb_data;

    logic [31:0]          trace_mem [TRACE_WORDS];
    rv_isa_pkg::word_t    imem [IMEM_WORDS];
    int                   prog_len = 0;
    int                   exp_count = 0;
    rv_isa_pkg::reg_idx_t exp_rd [EXP_MAX];
    rv_isa_pkg::word_t    exp_data [EXP_MAX];
    logic                 trace_loaded = 1'b0;

    int                   seen;
    int                   check_errors;
    int                   assert_errors;

    // ------------------------------------------------------------------------
    // clock, DUT and instruction memory
    // ------------------------------------------------------------------------
    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rv_core #(
        .RESET_PC   (RESET_PC),
        .DMEM_WORDS (DMEM_WORDS)
    ) u_rv_core (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_imem_data (imem_data),
        .o_imem_addr (imem_addr),
        .o_wb_valid  (wb_valid),
        .o_wb_rd     (wb_rd),
        .o_wb_data   (wb_data)
    );

    // same-cycle fetch, nop past the program end
    assign fetch_idx = imem_addr >> 2;
    assign imem_data = (fetch_idx < rv_isa_pkg::word_t'(prog_len)) ?
                       imem[fetch_idx[IMEM_AW-1:0]] : rv_isa_pkg::NOP_INSTR;

    rv_core_checker #(
        .EXP_MAX  (EXP_MAX),
        .FIRST_PC (RESET_PC)
    ) u_checker (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_imem_addr (imem_addr),
        .i_wb_valid  (wb_valid),
        .i_wb_rd     (wb_rd),
        .i_wb_data   (wb_data),
        .i_exp_count (exp_count),
        .i_exp_rd    (exp_rd),
        .i_exp_data  (exp_data),
        .o_seen      (seen),
        .o_errors    (check_errors)
    );

    assign assert_errors = u_rv_core.u_rv_core_assert.failures;

    // word count, program, writeback count, then rd / value pairs
    task automatic load_trace();
        int pos;
        $readmemh("tests/rv_core_trace.txt", trace_mem);
        prog_len = trace_mem[0];
        for (int i = 0; i < prog_len; i++)
            imem[i] = trace_mem[1 + i];
        pos       = prog_len + 1;
        exp_count = trace_mem[pos];
        for (int i = 0; i < exp_count; i++)
        begin
            exp_rd[i]   = trace_mem[pos + 1 + 2 * i][4:0];
            exp_data[i] = trace_mem[pos + 2 + 2 * i];
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial
    begin
        rst = 1'b1;
        load_trace();
        trace_loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        while (seen < exp_count)
            @(posedge clk);
        repeat (DRAIN_CYCLES) @(posedge clk);  // catch late extra writebacks
        $display("summary: %0d of %0d writebacks seen, %0d check errors, %0d assertion failures",
                 seen, exp_count, check_errors, assert_errors);
        if (check_errors == 0 && assert_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

    initial
    begin : watchdog
        int limit;
        wait (trace_loaded);
        limit = 20 * prog_len + 50;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, %0d expected writebacks never arrived",
                 limit, exp_count - seen);
        $display("summary: %0d of %0d writebacks seen, %0d check errors, %0d assertion failures",
                 seen, exp_count, check_errors, assert_errors);
        $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/rv_core_trace.txt ====
// program word count, then one instruction word per line,
// then writeback count, then one writeback per line: rd, expected value
16
00500093  // 00 addi x1, x0, 5
ffd00113  // 04 addi x2, x0, -3
002081b3  // 08 add  x3, x1, x2
40118233  // 0c sub  x4, x3, x1
001222b3  // 10 slt  x5, x4, x1
0042c333  // 14 xor  x6, x5, x4
001363b3  // 18 or   x7, x6, x1
0013f433  // 1c and  x8, x7, x1
00708013  // 20 addi x0, x1, 7
001004b3  // 24 add  x9, x0, x1
00602423  // 28 sw   x6, 8(x0)
00802503  // 2c lw   x10, 8(x0)
001505b3  // 30 add  x11, x10, x1
00558663  // 34 beq  x11, x5, +12
06300613  // 38 addi x12, x0, 99
06300693  // 3c addi x13, x0, 99
00909663  // 40 bne  x1, x9, +12
00c0076f  // 44 jal  x14, +12
04d00793  // 48 addi x15, x0, 77
04d00813  // 4c addi x16, x0, 77
00170893  // 50 addi x17, x14, 1
00388933  // 54 add  x18, x17, x3
0e
01 00000005
02 fffffffd
03 00000002
04 fffffffd
05 00000001
06 fffffffc
07 fffffffd
08 00000005
09 00000005
0a fffffffc
0b 00000001
0e 00000048
11 00000049
12 0000004b

// ==== flist.f ====
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_hazard_unit.sv
hw/rv_execute.sv
hw/rv_data_mem.sv
hw/rv_core.sv
tests/rv_core_checker.sv
tests/rv_core_assert.sv
tests/tb_rv_core.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_rv_core
FLIST      := flist.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
